//--- testbench/scsiStreamInput.txt
// Columns: opcode _ flag or lane mask _ 32-bit data, one command per line
// Opcodes: 1 byte, 2 flush, 3 read (data, mask), 4 read on empty, 5 hostEmpty, 6 scsiReady, 7 idle
// Full word packs big-endian
1_0_00000011
1_0_00000022
1_0_00000033
1_0_00000044
3_f_11223344
// Two bytes and a flush leave the low half zero
1_0_00000055
1_0_00000066
2_0_00000000
3_c_55660000
// Four words fill the FIFO and stall the SCSI side
1_0_000000a1
1_0_000000a2
1_0_000000a3
1_0_000000a4
1_0_000000b1
1_0_000000b2
1_0_000000b3
1_0_000000b4
1_0_000000c1
1_0_000000c2
1_0_000000c3
1_0_000000c4
1_0_000000d1
1_0_000000d2
1_0_000000d3
1_0_000000d4
7_0_00000002
6_0_00000000
5_0_00000000
3_f_a1a2a3a4
// A fifth word goes in once a slot is free
1_0_000000e1
1_0_000000e2
1_0_000000e3
1_0_000000e4
3_f_b1b2b3b4
3_f_c1c2c3c4
3_f_d1d2d3d4
3_f_e1e2e3e4
// Read on an empty FIFO, then a flush with nothing held
7_0_00000003
5_1_00000000
4_0_00000000
2_0_00000000
7_0_00000003
5_1_00000000
6_1_00000000
0_0_00000000

//--- scsiDmaDatapath.f
rtl/dmaDatapathPkg.sv
rtl/scsiByteGather.sv
rtl/dmaWordFifo.sv
rtl/hostBusDriver.sv
rtl/scsiDmaDatapath.sv
testbench/scsiDmaDatapath_props.sv
testbench/tbClockGen.sv
testbench/scsiDmaDatapathTb.sv

//--- Makefile
# Verilator build and run for the SCSI DMA read datapath
# Override any variable on the command line, e.g. make BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= scsiDmaDatapathTb
FLIST     ?= scsiDmaDatapath.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST OK

SOURCES := $(shell grep -v '^+' $(FLIST))
DATA    := testbench/scsiStreamInput.txt
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# Runs from the project root so the data file path resolves
run: $(BIN) $(DATA)
	./$(BIN) 2>&1 | tee $(LOG)

# Pass or fail is taken from the log alone
check: run
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/scsiDmaDatapathTb.sv
// ----------------------------
// Run from the project root; commands come from testbench/scsiStreamInput.txt
// ----------------------------
`timescale 1ns/1ps

module scsiDmaDatapathTb;
    import dmaDatapathPkg::*;

    localparam int    FIFO_DEPTH     = 4;
    localparam int    CMD_W          = 40;
    localparam int    CMD_MAX        = 128;
    localparam int    CYCLES_PER_CMD = 20;
    localparam string DATA_FILE      = "testbench/scsiStreamInput.txt";

    // Opcodes in the top nibble of each command word
    localparam logic [3:0] OP_END         = 4'h0;
    localparam logic [3:0] OP_BYTE        = 4'h1;
    localparam logic [3:0] OP_FLUSH       = 4'h2;
    localparam logic [3:0] OP_READ        = 4'h3;
    localparam logic [3:0] OP_EMPTY_READ  = 4'h4;
    localparam logic [3:0] OP_CHECK_EMPTY = 4'h5;
    localparam logic [3:0] OP_CHECK_READY = 4'h6;
    localparam logic [3:0] OP_IDLE        = 4'h7;

    logic     clk;
    logic     rstN;
    scsiByteT scsiByte;
    logic     scsiByteValid;
    logic     scsiFlush;
    logic     scsiReady;
    logic     hostRead;
    hostWordT hostData;
    laneMaskT hostLaneMask;
    logic     hostValid;
    logic     oeHigh;
    logic     oeLow;
    logic     hostEmpty;

    logic [CMD_W-1:0] cmdMem [CMD_MAX];
    int numCmds;
    int cycleCount;
    int timeoutLimit;
    // Words handed over and not yet read, and bytes in the open word
    int wordsHeld;
    int bytesHeld;

    tbClockGen #(
        .CLK_PERIOD   (20),
        .RESET_CYCLES (4)
    ) clockGen_i (
        .clk  (clk),
        .rstN (rstN)
    );

    scsiDmaDatapath #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) scsiDmaDatapath_i (
        .clk           (clk),
        .rstN          (rstN),
        .scsiByte      (scsiByte),
        .scsiByteValid (scsiByteValid),
        .scsiFlush     (scsiFlush),
        .scsiReady     (scsiReady),
        .hostRead      (hostRead),
        .hostData      (hostData),
        .hostLaneMask  (hostLaneMask),
        .hostValid     (hostValid),
        .oeHigh        (oeHigh),
        .oeLow         (oeLow),
        .hostEmpty     (hostEmpty)
    );

    task automatic failAndStop();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic checkWord(input string name, input hostWordT actual, input hostWordT expected);
        if (actual !== expected) begin
            $display("CHECK FAILED time=%0t signal=%s actual=%h expected=%h",
                     $time, name, actual, expected);
            failAndStop();
        end
    endtask

    task automatic checkMask(input string name, input laneMaskT actual, input laneMaskT expected);
        if (actual !== expected) begin
            $display("CHECK FAILED time=%0t signal=%s actual=%b expected=%b",
                     $time, name, actual, expected);
            failAndStop();
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("CHECK FAILED time=%0t signal=%s actual=%b expected=%b",
                     $time, name, actual, expected);
            failAndStop();
        end
    endtask

    // Commands end at the first zero or unloaded opcode
    function automatic int countCommands();
        int n;
        n = 0;
        while ((n < CMD_MAX) && !$isunknown(cmdMem[n][CMD_W-1 -: 4]) &&
               (cmdMem[n][CMD_W-1 -: 4] != OP_END)) begin
            n++;
        end
        return n;
    endfunction

    // A word closed into an empty FIFO becomes readable two cycles after its last strobe
    task automatic confirmArrivalDelay();
        checkFlag("hostEmpty", hostEmpty, 1'b1);
        @(negedge clk);
        checkFlag("hostEmpty", hostEmpty, 1'b1);
        @(negedge clk);
        checkFlag("hostEmpty", hostEmpty, 1'b0);
    endtask

    task automatic sendByte(input scsiByteT value);
        while (scsiReady !== 1'b1) @(negedge clk);
        scsiByte      = value;
        scsiByteValid = 1'b1;
        @(negedge clk);
        scsiByteValid = 1'b0;
        bytesHeld++;
        // The fourth byte closes a word
        if (bytesHeld == WORD_BYTES) begin
            bytesHeld = 0;
            wordsHeld++;
            if (wordsHeld == 1) begin
                confirmArrivalDelay();
            end
        end
    endtask

    task automatic sendFlush();
        while (scsiReady !== 1'b1) @(negedge clk);
        scsiFlush = 1'b1;
        @(negedge clk);
        scsiFlush = 1'b0;
        // Only a partial word turns into a FIFO entry
        if (bytesHeld != 0) begin
            wordsHeld++;
            if (wordsHeld == 1) begin
                confirmArrivalDelay();
            end
        end
        bytesHeld = 0;
    endtask

    task automatic readWord(input hostWordT expWord, input laneMaskT expMask);
        logic expHigh;
        logic expLow;
        // Each half-word enable follows the mask bits of its two lanes
        expHigh = expMask[3] | expMask[2];
        expLow  = expMask[1] | expMask[0];
        while (hostEmpty !== 1'b0) @(negedge clk);
        hostRead = 1'b1;
        @(negedge clk);
        hostRead = 1'b0;
        // The word shows in the cycle right after the edge that sampled the read
        checkFlag("hostValid", hostValid, 1'b1);
        checkWord("hostData", hostData, expWord);
        checkMask("hostLaneMask", hostLaneMask, expMask);
        checkFlag("oeHigh", oeHigh, expHigh);
        checkFlag("oeLow", oeLow, expLow);
        // hostValid is a single-cycle pulse and the data bus holds afterwards
        @(negedge clk);
        checkFlag("hostValid", hostValid, 1'b0);
        checkFlag("oeHigh", oeHigh, 1'b0);
        checkFlag("oeLow", oeLow, 1'b0);
        checkWord("hostData", hostData, expWord);
        wordsHeld--;
    endtask

    task automatic readWhileEmpty();
        checkFlag("hostEmpty", hostEmpty, 1'b1);
        hostRead = 1'b1;
        @(negedge clk);
        hostRead = 1'b0;
        // An accepted read would show hostValid right here
        checkFlag("hostValid", hostValid, 1'b0);
        @(negedge clk);
        checkFlag("hostValid", hostValid, 1'b0);
    endtask

    task automatic checkReadyLevel(input logic expReady);
        logic predicted;
        // The SCSI side stalls once FIFO_DEPTH words wait in the FIFO
        predicted = (wordsHeld < FIFO_DEPTH);
        if (predicted !== expReady) begin
            $display("Data file expects scsiReady %0b but depth %0d with %0d words gives %0b",
                     expReady, FIFO_DEPTH, wordsHeld, predicted);
            failAndStop();
        end
        checkFlag("scsiReady", scsiReady, expReady);
    endtask

    task automatic runCommand(input logic [CMD_W-1:0] cmd);
        logic [3:0] op;
        laneMaskT   flag;
        hostWordT   data;
        op   = cmd[CMD_W-1 -: 4];
        flag = cmd[CMD_W-5 -: 4];
        data = cmd[31:0];
        case (op)
            OP_BYTE:        sendByte(data[BYTE_BITS-1:0]);
            OP_FLUSH:       sendFlush();
            OP_READ:        readWord(data, flag);
            OP_EMPTY_READ:  readWhileEmpty();
            OP_CHECK_EMPTY: checkFlag("hostEmpty", hostEmpty, flag[0]);
            OP_CHECK_READY: checkReadyLevel(flag[0]);
            OP_IDLE:        repeat (data[7:0]) @(negedge clk);
            default: begin
                $display("Unknown command %h in %s", cmd, DATA_FILE);
                failAndStop();
            end
        endcase
    endtask

    // Cycle budget scales with the number of commands in the data file
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if ((timeoutLimit != 0) && (cycleCount > timeoutLimit)) begin
            $display("Timeout: the commands did not finish within %0d cycles", timeoutLimit);
            failAndStop();
        end
    end

    initial begin
        scsiByte      = '0;
        scsiByteValid = 1'b0;
        scsiFlush     = 1'b0;
        hostRead      = 1'b0;
        cycleCount    = 0;
        timeoutLimit  = 0;
        wordsHeld     = 0;
        bytesHeld     = 0;
        $readmemh(DATA_FILE, cmdMem);
        numCmds = countCommands();
        if (numCmds == 0) begin
            $display("No commands could be read from %s", DATA_FILE);
            failAndStop();
        end
        timeoutLimit = CYCLES_PER_CMD * numCmds;
        wait (rstN === 1'b1);
        @(negedge clk);
        // Idle state right after reset
        checkFlag("hostEmpty", hostEmpty, 1'b1);
        checkFlag("scsiReady", scsiReady, 1'b1);
        checkFlag("hostValid", hostValid, 1'b0);
        checkFlag("oeHigh", oeHigh, 1'b0);
        checkFlag("oeLow", oeLow, 1'b0);
        checkWord("hostData", hostData, '0);
        for (int i = 0; i < numCmds; i++) begin
            runCommand(cmdMem[i]);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

//--- testbench/tbClockGen.sv
// ----------------------------
// Clock runs from time zero; reset is released on a falling edge
// ----------------------------
`timescale 1ns/1ps

module tbClockGen #(
    parameter int CLK_PERIOD   = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rstN
);

    // Free-running clock, first rising edge at half a period
    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Reset spans RESET_CYCLES rising edges and drops where the stimulus changes
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

//--- testbench/scsiDmaDatapath_props.sv
// ----------------------------
// Checks the SCSI strobe rule and the bus enables, only outside reset
// ----------------------------
`timescale 1ns/1ps

module scsiDmaDatapath_props (
    input logic clk,
    input logic rstN,
    input logic scsiByteValid,
    input logic scsiFlush,
    input logic scsiReady,
    input logic hostRead,
    input logic hostEmpty,
    input logic hostValid,
    input logic oeHigh,
    input logic oeLow
);

    // The SCSI side may only strobe while the datapath can take the byte or flush
    strobeOnlyWhenReady: assert property (
        @(posedge clk) disable iff (!rstN)
        (scsiByteValid || scsiFlush) |-> scsiReady
    ) else $error("SCSI byte or flush strobe while scsiReady is low");

    // A read against an empty FIFO must not turn into a bus cycle
    noValidAfterEmptyRead: assert property (
        @(posedge clk) disable iff (!rstN)
        (hostRead && hostEmpty) |=> !hostValid
    ) else $error("hostValid followed a read on an empty FIFO");

    // Either half of the bus is only opened during a valid cycle
    enableOnlyWhenValid: assert property (
        @(posedge clk) disable iff (!rstN)
        (oeHigh || oeLow) |-> hostValid
    ) else $error("Half-word enable high without hostValid");

endmodule

// Attached to every instance of the datapath top level
bind scsiDmaDatapath scsiDmaDatapath_props scsiDmaDatapathProps_i (
    .clk           (clk),
    .rstN          (rstN),
    .scsiByteValid (scsiByteValid),
    .scsiFlush     (scsiFlush),
    .scsiReady     (scsiReady),
    .hostRead      (hostRead),
    .hostEmpty     (hostEmpty),
    .hostValid     (hostValid),
    .oeHigh        (oeHigh),
    .oeLow         (oeLow)
);

//--- rtl/scsiDmaDatapath.sv
// ----------------------------
// Read direction only; two cycles from the last byte of a word to a readable word
// ----------------------------
`timescale 1ns/1ps

module scsiDmaDatapath #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rstN,

    // SCSI side
    input  dmaDatapathPkg::scsiByteT scsiByte,
    input  logic                     scsiByteValid,
    input  logic                     scsiFlush,
    output logic                     scsiReady,

    // Host side
    input  logic                     hostRead,
    output dmaDatapathPkg::hostWordT hostData,
    output dmaDatapathPkg::laneMaskT hostLaneMask,
    output logic                     hostValid,
    output logic                     oeHigh,
    output logic                     oeLow,
    output logic                     hostEmpty
);
    import dmaDatapathPkg::*;

    // Producer to FIFO
    hostWordT gatherWord;
    laneMaskT gatherMask;
    logic     gatherPush;
    logic     fifoFull;

    // FIFO to consumer
    hostWordT fifoWord;
    laneMaskT fifoMask;
    logic     fifoEmpty;
    logic     fifoPop;

    // Packs SCSI bytes into words and stalls the SCSI side on a full FIFO
    scsiByteGather scsiByteGather_i (
        .clk           (clk),
        .rstN          (rstN),
        .scsiByte      (scsiByte),
        .scsiByteValid (scsiByteValid),
        .scsiFlush     (scsiFlush),
        .fifoFull      (fifoFull),
        .scsiReady     (scsiReady),
        .gatherWord    (gatherWord),
        .gatherMask    (gatherMask),
        .gatherPush    (gatherPush)
    );

    // Decouples the SCSI byte rate from host read timing
    dmaWordFifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dmaWordFifo_i (
        .clk        (clk),
        .rstN       (rstN),
        .gatherWord (gatherWord),
        .gatherMask (gatherMask),
        .gatherPush (gatherPush),
        .fifoPop    (fifoPop),
        .fifoWord   (fifoWord),
        .fifoMask   (fifoMask),
        .fifoFull   (fifoFull),
        .fifoEmpty  (fifoEmpty)
    );

    // Hands one word per read strobe to the host bus with its half-word enables
    hostBusDriver hostBusDriver_i (
        .clk          (clk),
        .rstN         (rstN),
        .hostRead     (hostRead),
        .fifoWord     (fifoWord),
        .fifoMask     (fifoMask),
        .fifoEmpty    (fifoEmpty),
        .fifoPop      (fifoPop),
        .hostData     (hostData),
        .hostLaneMask (hostLaneMask),
        .hostValid    (hostValid),
        .oeHigh       (oeHigh),
        .oeLow        (oeLow),
        .hostEmpty    (hostEmpty)
    );

endmodule

//--- rtl/hostBusDriver.sv
// ----------------------------
// Back-to-back reads give back-to-back hostValid cycles
// ----------------------------
`timescale 1ns/1ps

module hostBusDriver (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     hostRead,
    input  dmaDatapathPkg::hostWordT fifoWord,
    input  dmaDatapathPkg::laneMaskT fifoMask,
    input  logic                     fifoEmpty,
    output logic                     fifoPop,
    output dmaDatapathPkg::hostWordT hostData,
    output dmaDatapathPkg::laneMaskT hostLaneMask,
    output logic                     hostValid,
    output logic                     oeHigh,
    output logic                     oeLow,
    output logic                     hostEmpty
);
    import dmaDatapathPkg::*;

    // A read counts only when the FIFO has a word to give
    logic readTake;

    // Lane mask split into the two half-words of the host bus
    logic [LANES_PER_HALF-1:0] highLanes;
    logic [LANES_PER_HALF-1:0] lowLanes;

    // Reads against an empty FIFO are dropped here and never reach the pop port
    assign readTake = hostRead & ~fifoEmpty;
    assign fifoPop  = readTake;

    // The head word is captured at the same edge that pops it
    always_ff @(posedge clk) begin
        if (!rstN) begin
            hostData     <= '0;
            hostLaneMask <= '0;
            hostValid    <= 1'b0;
        end else begin
            hostValid <= readTake;
            // Data and mask hold between reads so the bus stays stable
            if (readTake) begin
                hostData     <= fifoWord;
                hostLaneMask <= fifoMask;
            end
        end
    end

    assign highLanes = hostLaneMask[WORD_BYTES-1 -: LANES_PER_HALF];
    assign lowLanes  = hostLaneMask[LANES_PER_HALF-1:0];

    // Each half-word enable opens its half of the bus only during hostValid
    // and only when that half carries at least one received byte
    // A flush of one or two bytes therefore leaves the low half disabled
    assign oeHigh = hostValid & (|highLanes);
    assign oeLow  = hostValid & (|lowLanes);

    // Host sees the FIFO level directly
    assign hostEmpty = fifoEmpty;

endmodule

//--- rtl/dmaWordFifo.sv
// ----------------------------
// FIFO_DEPTH must be a power of two, at least 2; words show one cycle after push
// ----------------------------
`timescale 1ns/1ps

module dmaWordFifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  dmaDatapathPkg::hostWordT gatherWord,
    input  dmaDatapathPkg::laneMaskT gatherMask,
    input  logic                     gatherPush,
    input  logic                     fifoPop,
    output dmaDatapathPkg::hostWordT fifoWord,
    output dmaDatapathPkg::laneMaskT fifoMask,
    output logic                     fifoFull,
    output logic                     fifoEmpty
);
    import dmaDatapathPkg::*;

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    // Storage for the word and its lane mask side by side
    hostWordT wordMem [FIFO_DEPTH];
    laneMaskT maskMem [FIFO_DEPTH];

    // Pointers carry one extra wrap bit to tell full from empty
    logic [ADDR_W:0] wrPtr;
    logic [ADDR_W:0] rdPtr;
    // Write pointer as the read side sees it, one cycle behind wrPtr
    logic [ADDR_W:0] wrPtrShown;

    logic pushOk;
    logic popOk;

    // Guard both ports so a stray strobe cannot corrupt the pointers
    assign pushOk = gatherPush & ~fifoFull;
    assign popOk  = fifoPop & ~fifoEmpty;

    // Full compares against the live write pointer so no push can overrun
    assign fifoFull = (wrPtr[ADDR_W] != rdPtr[ADDR_W]) &&
                      (wrPtr[ADDR_W-1:0] == rdPtr[ADDR_W-1:0]);

    // Empty uses the delayed pointer, so a new word shows after the RAM write settles
    assign fifoEmpty = (rdPtr == wrPtrShown);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            wrPtrShown <= '0;
        end else begin
            wrPtrShown <= wrPtr;
            if (pushOk) begin
                wrPtr <= wrPtr + 1'b1;
            end
            // Push and pop in the same cycle move both pointers independently
            if (popOk) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pushOk) begin
            wordMem[wrPtr[ADDR_W-1:0]] <= gatherWord;
            maskMem[wrPtr[ADDR_W-1:0]] <= gatherMask;
        end
    end

    // First-word-fall-through, the head entry is always on the outputs
    // Contents are meaningless while fifoEmpty is high
    assign fifoWord = wordMem[rdPtr[ADDR_W-1:0]];
    assign fifoMask = maskMem[rdPtr[ADDR_W-1:0]];

endmodule

//--- rtl/scsiByteGather.sv
// ----------------------------
// A byte and a flush in the same cycle take the byte; the flush is dropped
// ----------------------------
`timescale 1ns/1ps

module scsiByteGather (
    input  logic                     clk,
    input  logic                     rstN,
    input  dmaDatapathPkg::scsiByteT scsiByte,
    input  logic                     scsiByteValid,
    input  logic                     scsiFlush,
    input  logic                     fifoFull,
    output logic                     scsiReady,
    output dmaDatapathPkg::hostWordT gatherWord,
    output dmaDatapathPkg::laneMaskT gatherMask,
    output logic                     gatherPush
);
    import dmaDatapathPkg::*;

    // Count value seen while the last byte of a word arrives
    localparam byteCountT LAST_BYTE = byteCountT'(WORD_BYTES - 1);

    // Bytes of the word being gathered, stored in their final lanes
    byteCountT byteCount;
    hostWordT  shiftWord;
    // Word with the incoming byte merged in
    hostWordT  nextWord;
    // Lane mask for a flush of a partial word
    laneMaskT  flushMask;

    // Finished word waiting to go into the FIFO
    logic      pendValid;
    hostWordT  pendWord;
    laneMaskT  pendMask;

    // True when the held word moves into the FIFO at the next edge
    logic      pushNow;

    // The first byte of a word starts from zero so unused low lanes read as zero
    // Each later byte lands one lane below the byte before it
    always_comb begin
        nextWord = (byteCount == '0) ? '0 : shiftWord;
        nextWord[BYTE_BITS*(LAST_BYTE - byteCount) +: BYTE_BITS] = scsiByte;
    end

    // Mask has one bit per received byte, counted down from the top lane
    // One byte gives 1000, two give 1100, three give 1110
    assign flushMask = ~(laneMaskT'('1) >> byteCount);

    // The held word only leaves when the FIFO has room
    assign pushNow = pendValid & ~fifoFull;

    // Control state
    always_ff @(posedge clk) begin
        if (!rstN) begin
            byteCount <= '0;
            pendValid <= 1'b0;
        end else begin
            // A push frees the holding slot; a new word below may refill it at once
            if (pushNow) begin
                pendValid <= 1'b0;
            end
            if (scsiByteValid) begin
                byteCount <= byteCount + byteCountT'(1);
                if (byteCount == LAST_BYTE) begin
                    pendValid <= 1'b1;
                end
            end else if (scsiFlush && (byteCount != '0)) begin
                // Flush of an empty word is a no-op
                byteCount <= '0;
                pendValid <= 1'b1;
            end
        end
    end

    // Payload registers follow the same decisions without a reset
    always_ff @(posedge clk) begin
        if (scsiByteValid) begin
            shiftWord <= nextWord;
            if (byteCount == LAST_BYTE) begin
                pendWord <= nextWord;
                pendMask <= '1;
            end
        end else if (scsiFlush && (byteCount != '0)) begin
            pendWord <= shiftWord;
            pendMask <= flushMask;
        end
    end

    assign gatherWord = pendWord;
    assign gatherMask = pendMask;
    assign gatherPush = pushNow;

    // A held word waits only while the FIFO is full, so the full flag alone
    // covers both stall cases
    assign scsiReady = ~fifoFull;

endmodule

//--- rtl/dmaDatapathPkg.sv
// ----------------------------
// Read direction only, SCSI bytes packed big-endian into host words
// ----------------------------

package dmaDatapathPkg;

    // Host words are four SCSI bytes wide
    localparam int WORD_BYTES = 4;

    // A half-word covers two byte lanes, one per output enable
    localparam int LANES_PER_HALF = WORD_BYTES / 2;

    // Width of one SCSI data byte in bits
    localparam int BYTE_BITS = 8;

    // One byte as it comes off the 8-bit SCSI data port
    typedef logic [BYTE_BITS-1:0] scsiByteT;

    // One host word
    // The first byte received sits in the top byte, so the word reads big-endian
    typedef logic [WORD_BYTES*BYTE_BITS-1:0] hostWordT;

    // Byte-lane valid mask, one bit per byte of a host word
    // Bit 3 marks the top byte, which is the first byte received
    typedef logic [WORD_BYTES-1:0] laneMaskT;

    // Count of bytes gathered into the current word, 0 to WORD_BYTES-1
    // The count wraps to zero when the last byte of a word arrives
    typedef logic [$clog2(WORD_BYTES)-1:0] byteCountT;

endpackage
